// File: tb/mailbox_cases.txt
# core wr addr size trans wdata, then expected hrdata hresp intr_c0 intr_c1 (all hex)
# size 0 byte 1 half 2 word 3 bad, trans 2 NONSEQ 3 SEQ, hresp 0 OKAY 1 ERROR
0 1 40030008 2 2 00000001 00000000 0 0 0
0 1 4003000C 2 2 A5A51234 00000000 0 0 1
1 0 40030010 2 2 00000000 00000003 0 0 1
0 0 40030004 2 2 00000000 00000002 0 0 1
0 1 4003000C 2 2 DEADBEEF 00000000 1 0 1
1 0 4003000C 2 2 00000000 A5A51234 0 0 0
1 0 40030010 2 2 00000000 00000000 0 0 0
1 0 40030004 2 2 00000000 00000000 0 0 0
1 1 40030014 2 2 00000001 00000000 0 0 0
1 1 40030018 2 2 0BADF00D 00000000 0 1 0
0 0 4003001C 2 2 00000000 00000003 0 1 0
1 0 40030004 2 2 00000000 00000001 0 1 0
0 0 40030018 2 2 00000000 0BADF00D 0 0 0
0 0 4003001C 2 2 00000000 00000000 0 0 0
0 1 4003000C 0 2 123456C3 00000000 0 0 1
1 0 4003000C 2 2 00000000 000000C3 0 0 0
0 1 4003000C 1 2 8765ABCD 00000000 0 0 1
1 0 4003000C 2 2 00000000 0000ABCD 0 0 0
0 1 40030018 2 2 11111111 00000000 1 0 0
0 0 4003001C 2 2 00000000 00000000 0 0 0
0 1 4003000C 3 2 22222222 00000000 1 0 0
1 0 40030010 2 2 00000000 00000000 0 0 0
0 1 4003000C 2 3 33333333 00000000 1 0 0
1 0 40030010 2 2 00000000 00000000 0 0 0
1 0 4003000C 2 3 00000000 00000000 1 0 0

// File: verilog.f
src/mbox_map_pkg.sv
src/mbox_ahb_pkg.sv
src/mbox_reg_if.sv
src/mbox_ahb_port.sv
src/mbox_channel.sv
src/mailbox_top.sv
tb/mailbox_clk_gen.sv
tb/tb_mailbox.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mailbox testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_mailbox -o tb_mailbox
out=$(./obj_dir/tb_mailbox)
echo "$out"

if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1

// File: tb/tb_mailbox.sv
`timescale 1ns/1ps
//########################################
// Mailbox testbench, one AHB transfer per case
// Cases come from tb/mailbox_cases.txt
// Run from the project root so that path resolves
// Inputs change 1 ns after the rising edge
// hrdata and hresp sampled mid data phase
// Interrupts sampled after the data phase ends
//########################################
module tb_mailbox
    import mbox_map_pkg::*;
    import mbox_ahb_pkg::*;
();

    typedef struct packed {
        logic       core;   // 0 or 1
        logic       wr;
        mbox_word_t addr;
        logic [2:0] size;
        logic [1:0] trans;
        mbox_word_t wdata;
        mbox_word_t rdata;  // Expected values from here on
        logic [1:0] resp;
        logic       i0;
        logic       i1;
    } case_t;

    logic       hclk, hrst_b, hsel;
    logic       c0_hwrite, c1_hwrite;
    mbox_word_t c0_haddr, c1_haddr;
    htrans_e    c0_htrans, c1_htrans;
    hsize_e     c0_hsize, c1_hsize;
    mbox_word_t c0_hwdata, c1_hwdata;
    mbox_word_t c0_hrdata, c1_hrdata;
    logic       c0_hready, c1_hready;
    hresp_e     c0_hresp, c1_hresp;
    logic       intr_c0, intr_c1;

    case_t cases[$];
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    cycle_limit = 100; // Raised once the cases are loaded

    mailbox_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(5)) u_clk_gen (
        .hclk   (hclk),
        .hrst_b (hrst_b)
    );

    mailbox_top #(.BASE_ADDR(MBOX_BASE_ADDR)) u_mailbox_top (
        .hclk      (hclk),
        .hrst_b    (hrst_b),
        .hsel      (hsel),
        .c0_hwrite (c0_hwrite),
        .c0_haddr  (c0_haddr),
        .c0_htrans (c0_htrans),
        .c0_hsize  (c0_hsize),
        .c0_hwdata (c0_hwdata),
        .c0_hrdata (c0_hrdata),
        .c0_hready (c0_hready),
        .c0_hresp  (c0_hresp),
        .c1_hwrite (c1_hwrite),
        .c1_haddr  (c1_haddr),
        .c1_htrans (c1_htrans),
        .c1_hsize  (c1_hsize),
        .c1_hwdata (c1_hwdata),
        .c1_hrdata (c1_hrdata),
        .c1_hready (c1_hready),
        .c1_hresp  (c1_hresp),
        .intr_c0   (intr_c0),
        .intr_c1   (intr_c1)
    );

    // Compare and log a mismatch in hex
    task automatic check_val(input string name, input mbox_word_t got, input mbox_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Skips blank lines and # comments
    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [10];
        case_t       c;
        fd = $fopen("tb/mailbox_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/mailbox_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                        f[4], f[5], f[6], f[7], f[8], f[9]);
            if (n != 10) begin
                $display("Malformed line in cases file: %s", line);
                errors++;
                continue;
            end
            c.core  = f[0][0];
            c.wr    = f[1][0];
            c.addr  = f[2];
            c.size  = f[3][2:0];
            c.trans = f[4][1:0];
            c.wdata = f[5];
            c.rdata = f[6];
            c.resp  = f[7][1:0];
            c.i0    = f[8][0];
            c.i1    = f[9][0];
            cases.push_back(c);
        end
        $fclose(fd);
    endtask

    // Both ports back to idle
    task automatic idle_bus();
        hsel      = 1'b0;
        c0_htrans = IDLE;
        c1_htrans = IDLE;
    endtask

    task automatic run_case(input int idx);
        case_t      c;
        mbox_word_t got_rdata;
        hresp_e     got_resp;
        logic       got_ready;
        int         err_before;
        c          = cases[idx];
        err_before = errors;
        @(posedge hclk);
        #1; // Address phase
        hsel = 1'b1;
        if (c.core == 1'b0) begin
            c0_hwrite = c.wr;
            c0_haddr  = c.addr;
            c0_htrans = htrans_e'(c.trans);
            c0_hsize  = hsize_e'(c.size); // Bad sizes go through too
        end else begin
            c1_hwrite = c.wr;
            c1_haddr  = c.addr;
            c1_htrans = htrans_e'(c.trans);
            c1_hsize  = hsize_e'(c.size);
        end
        @(posedge hclk);
        #1; // Data phase
        idle_bus();
        c0_hwdata = (c.core == 1'b0 && c.wr) ? c.wdata : '0;
        c1_hwdata = (c.core == 1'b1 && c.wr) ? c.wdata : '0;
        @(negedge hclk);
        got_rdata = c.core ? c1_hrdata : c0_hrdata;
        got_resp  = c.core ? c1_hresp : c0_hresp;
        got_ready = c.core ? c1_hready : c0_hready;
        @(posedge hclk);
        #1; // Channel state updated at this edge
        check_val(c.core ? "c1_hrdata" : "c0_hrdata", got_rdata, c.rdata);
        check_val(c.core ? "c1_hresp" : "c0_hresp", 32'(got_resp), 32'(c.resp));
        check_val(c.core ? "c1_hready" : "c0_hready", {31'h0, got_ready}, 32'h1);
        check_val("intr_c0", {31'h0, intr_c0}, {31'h0, c.i0});
        check_val("intr_c1", {31'h0, intr_c1}, {31'h0, c.i1});
        $display("case %0d: core %0d %s 0x%08h %s", idx, c.core, c.wr ? "write" : "read",
                 c.addr, (errors == err_before) ? "ok" : "mismatch");
    endtask

    // Watchdog, limit set from the case count
    always @(posedge hclk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        hsel      = 1'b0;
        c0_hwrite = 1'b0;
        c1_hwrite = 1'b0;
        c0_haddr  = '0;
        c1_haddr  = '0;
        c0_htrans = IDLE;
        c1_htrans = IDLE;
        c0_hsize  = WORD;
        c1_hsize  = WORD;
        c0_hwdata = '0;
        c1_hwdata = '0;
        load_cases();
        if (cases.size() == 0) begin
            $display("No cases were read");
            errors++;
        end
        cycle_limit = cases.size() * 4 + 100; // ~3 cycles per case plus reset
        wait (hrst_b === 1'b1);
        foreach (cases[i]) begin
            run_case(i);
        end
        repeat (2) @(posedge hclk);
        $display("cases %0d, checks %0d, errors %0d", cases.size(), checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tb/mailbox_clk_gen.sv
`timescale 1ns/1ps
//########################################
// Testbench clock and reset source
// Reset low for RST_CYCLES rising edges
// Release comes 1 ns after an edge
//########################################
module mailbox_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 5
) (
    output logic hclk,
    output logic hrst_b
);

    initial begin
        hclk = 1'b0;
        forever #(PERIOD_NS / 2) hclk = ~hclk;
    end

    initial begin
        hrst_b = 1'b0;
        repeat (RST_CYCLES) @(posedge hclk);
        #1;
        hrst_b = 1'b1; // Sync reset seen low for RST_CYCLES edges
    end

endmodule

// File: src/mailbox_top.sv
`timescale 1ns/1ps
//########################################
// Two-core mailbox, one AHB-Lite port per core
// Ch0 runs core 0 to core 1, ch1 the other way
// hsel shared by both ports
// ACISR lags the interrupt lines by one cycle
//########################################
module mailbox_top
    import mbox_map_pkg::*;
    import mbox_ahb_pkg::*;
#(
    parameter mbox_word_t BASE_ADDR = MBOX_BASE_ADDR
) (
    input  logic       hclk,
    input  logic       hrst_b,
    input  logic       hsel,
    // Core 0
    input  logic       c0_hwrite,
    input  mbox_word_t c0_haddr,
    input  htrans_e    c0_htrans,
    input  hsize_e     c0_hsize,
    input  mbox_word_t c0_hwdata,
    output mbox_word_t c0_hrdata,
    output logic       c0_hready,
    output hresp_e     c0_hresp,
    // Core 1
    input  logic       c1_hwrite,
    input  mbox_word_t c1_haddr,
    input  htrans_e    c1_htrans,
    input  hsize_e     c1_hsize,
    input  mbox_word_t c1_hwdata,
    output mbox_word_t c1_hrdata,
    output logic       c1_hready,
    output hresp_e     c1_hresp,
    // Interrupts to the receiving cores
    output logic       intr_c0,
    output logic       intr_c1
);

    mbox_word_t acisr; // {.., intr_c1, intr_c0}

    mbox_reg_if ch0_snd_if (); // Port 0 to ch0
    mbox_reg_if ch0_rcv_if (); // Port 1 to ch0
    mbox_reg_if ch1_snd_if (); // Port 1 to ch1
    mbox_reg_if ch1_rcv_if (); // Port 0 to ch1

    mbox_ahb_port #(
        .BASE_ADDR (BASE_ADDR),
        .TX_CH     (0)
    ) u_port0 (
        .hclk   (hclk),
        .hrst_b (hrst_b),
        .hsel   (hsel),
        .hwrite (c0_hwrite),
        .haddr  (c0_haddr),
        .htrans (c0_htrans),
        .hsize  (c0_hsize),
        .hwdata (c0_hwdata),
        .hrdata (c0_hrdata),
        .hready (c0_hready),
        .hresp  (c0_hresp),
        .acisr  (acisr),
        .tx_bus (ch0_snd_if),
        .rx_bus (ch1_rcv_if)
    );

    mbox_ahb_port #(
        .BASE_ADDR (BASE_ADDR),
        .TX_CH     (1)
    ) u_port1 (
        .hclk   (hclk),
        .hrst_b (hrst_b),
        .hsel   (hsel),
        .hwrite (c1_hwrite),
        .haddr  (c1_haddr),
        .htrans (c1_htrans),
        .hsize  (c1_hsize),
        .hwdata (c1_hwdata),
        .hrdata (c1_hrdata),
        .hready (c1_hready),
        .hresp  (c1_hresp),
        .acisr  (acisr),
        .tx_bus (ch1_snd_if),
        .rx_bus (ch0_rcv_if)
    );

    mbox_channel u_ch0 (
        .hclk   (hclk),
        .hrst_b (hrst_b),
        .snd    (ch0_snd_if),
        .rcv    (ch0_rcv_if),
        .intr   (intr_c1) // Core 1 receives ch0
    );

    mbox_channel u_ch1 (
        .hclk   (hclk),
        .hrst_b (hrst_b),
        .snd    (ch1_snd_if),
        .rcv    (ch1_rcv_if),
        .intr   (intr_c0)
    );

    // Shared interrupt status, sampled every cycle
    always_ff @(posedge hclk) begin
        if (!hrst_b) begin
            acisr <= '0;
        end else begin
            acisr <= {30'h0, intr_c1, intr_c0};
        end
    end

endmodule

// File: src/mbox_channel.sv
`timescale 1ns/1ps
//########################################
// One direction of the mailbox, one word deep
// Sender writes ctrl and data, receiver pops on data read
// Interrupt is full AND enable
//########################################
module mbox_channel
    import mbox_map_pkg::*;
(
    input  logic     hclk,
    input  logic     hrst_b,
    mbox_reg_if.regs snd,
    mbox_reg_if.regs rcv,
    output logic     intr
);

    logic       int_en;  // Ctrl enable bit
    logic       full;    // Word not yet popped
    mbox_word_t data_q;  // Stored word
    mbox_word_t ctrl_word;
    mbox_word_t stat_word;
    logic       snd_data_wr;
    logic       rcv_pop;

    // Pick register by select, same view for both sides
    function automatic mbox_word_t reg_mux(input mbox_reg_e sel, input mbox_word_t c_w,
                                           input mbox_word_t d_w, input mbox_word_t s_w);
        mbox_word_t r;
        case (sel)
            CTRL:    r = c_w;
            DATA:    r = d_w;
            default: r = s_w;
        endcase
        return r;
    endfunction

    assign snd_data_wr = snd.wr_en && (snd.reg_sel == DATA);
    assign rcv_pop     = rcv.rd_en && (rcv.reg_sel == DATA); // Sender reads do not pop

    always_ff @(posedge hclk) begin
        if (!hrst_b) begin
            int_en <= 1'b0;
            full   <= 1'b0;
        end else begin
            if (rcv_pop) begin
                full <= 1'b0;
            end
            if (snd.wr_en && snd.reg_sel == CTRL) begin
                int_en <= snd.wdata[CTRL_INT_EN_BIT];
            end
            if (snd_data_wr) begin
                full <= 1'b1; // Fresh word beats a pop of an empty channel
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (snd_data_wr) begin
            data_q <= snd.wdata;
        end
    end

    assign intr = full && int_en;

    // Register views
    always_comb begin
        ctrl_word                  = '0;
        ctrl_word[CTRL_INT_EN_BIT] = int_en;
        stat_word                  = '0;
        stat_word[STAT_FULL_BIT]   = full;
        stat_word[STAT_INT_BIT]    = intr;
    end

    assign snd.rdata = reg_mux(snd.reg_sel, ctrl_word, data_q, stat_word);
    assign rcv.rdata = reg_mux(rcv.reg_sel, ctrl_word, data_q, stat_word);
    assign snd.full  = full;
    assign rcv.full  = full;

    // Receiver port must never write here
    a_rcv_no_write: assert property (@(posedge hclk) disable iff (!hrst_b)
        !rcv.wr_en);

    // Sender port holds off data writes until the pop
    a_no_overwrite: assert property (@(posedge hclk) disable iff (!hrst_b)
        snd_data_wr |-> !full);

endmodule

// File: src/mbox_ahb_port.sv
`timescale 1ns/1ps
//########################################
// AHB-Lite slave for one core, no wait states
// hready tied high, ERROR lasts one data-phase cycle
// Only single NONSEQ transfers, SEQ gets ERROR
// Byte and half writes keep the low lane only
// Writes allowed only to the core's own tx channel
//########################################
module mbox_ahb_port
    import mbox_map_pkg::*;
    import mbox_ahb_pkg::*;
#(
    parameter mbox_word_t BASE_ADDR = MBOX_BASE_ADDR,
    parameter int         TX_CH     = 0 // Channel this core sends on
) (
    input  logic       hclk,
    input  logic       hrst_b,
    input  logic       hsel,
    input  logic       hwrite,
    input  mbox_word_t haddr,
    input  htrans_e    htrans,
    input  hsize_e     hsize,
    input  mbox_word_t hwdata,
    output mbox_word_t hrdata,
    output logic       hready,
    output hresp_e     hresp,
    input  mbox_word_t acisr,
    mbox_reg_if.host   tx_bus,
    mbox_reg_if.host   rx_bus
);

    // Own channel vs the one we receive on
    localparam logic [7:0] TX_CTRL_OFS = (TX_CH == 0) ? CH0_CTRL_OFS : CH1_CTRL_OFS;
    localparam logic [7:0] TX_DATA_OFS = (TX_CH == 0) ? CH0_DATA_OFS : CH1_DATA_OFS;
    localparam logic [7:0] TX_STAT_OFS = (TX_CH == 0) ? CH0_STAT_OFS : CH1_STAT_OFS;
    localparam logic [7:0] RX_CTRL_OFS = (TX_CH == 0) ? CH1_CTRL_OFS : CH0_CTRL_OFS;
    localparam logic [7:0] RX_DATA_OFS = (TX_CH == 0) ? CH1_DATA_OFS : CH0_DATA_OFS;
    localparam logic [7:0] RX_STAT_OFS = (TX_CH == 0) ? CH1_STAT_OFS : CH0_STAT_OFS;

    logic       dp_act;   // Data phase of a selected transfer
    logic       dp_write;
    htrans_e    dp_trans;
    mbox_word_t dp_addr;
    hsize_e     dp_size;

    logic       in_range, hit_acisr, hit_tx, hit_rx;
    logic [7:0] ofs;
    mbox_reg_e  tx_sel, rx_sel;
    logic       seq_err, size_err, ro_err, full_err, err, xfer_ok;
    mbox_word_t wr_word;

    // Offset to register select, anything else is status
    function automatic mbox_reg_e sel_of(input logic [7:0] a, input logic [7:0] c_ofs,
                                         input logic [7:0] d_ofs);
        mbox_reg_e s;
        if (a == c_ofs) begin
            s = CTRL;
        end else if (a == d_ofs) begin
            s = DATA;
        end else begin
            s = STAT;
        end
        return s;
    endfunction

    // Address phase capture, every edge since hready is 1
    always_ff @(posedge hclk) begin
        if (!hrst_b) begin
            dp_act   <= 1'b0;
            dp_write <= 1'b0;
            dp_trans <= IDLE;
        end else begin
            dp_act   <= hsel && (htrans == NONSEQ || htrans == SEQ); // IDLE/BUSY ignored
            dp_write <= hwrite;
            dp_trans <= htrans;
        end
    end

    always_ff @(posedge hclk) begin
        dp_addr <= haddr;
        dp_size <= hsize;
    end

    // Decode
    assign ofs       = dp_addr[7:0];
    assign in_range  = (dp_addr[31:8] == BASE_ADDR[31:8]);
    assign hit_acisr = in_range && (ofs == ACISR_OFS);
    assign hit_tx    = in_range && (ofs == TX_CTRL_OFS || ofs == TX_DATA_OFS ||
                                    ofs == TX_STAT_OFS);
    assign hit_rx    = in_range && (ofs == RX_CTRL_OFS || ofs == RX_DATA_OFS ||
                                    ofs == RX_STAT_OFS);
    assign tx_sel    = sel_of(ofs, TX_CTRL_OFS, TX_DATA_OFS);
    assign rx_sel    = sel_of(ofs, RX_CTRL_OFS, RX_DATA_OFS);

    // Error checks
    assign seq_err  = (dp_trans == SEQ);
    assign size_err = !(dp_size inside {BYTE, HALF, WORD});
    assign ro_err   = dp_write && (hit_rx || hit_acisr); // Receiver side is read only
    assign full_err = dp_write && hit_tx && (tx_sel == DATA) && tx_bus.full; // No overwrite
    assign err      = dp_act && (seq_err || size_err || ro_err || full_err);
    assign xfer_ok  = dp_act && !err;

    // Low lane only, zero-extended
    always_comb begin
        case (dp_size)
            BYTE:    wr_word = {24'h0, hwdata[7:0]};
            HALF:    wr_word = {16'h0, hwdata[15:0]};
            default: wr_word = hwdata;
        endcase
    end

    // Strobes to the channels
    assign tx_bus.wr_en   = xfer_ok && dp_write && hit_tx;
    assign tx_bus.rd_en   = xfer_ok && !dp_write && hit_tx;
    assign tx_bus.reg_sel = tx_sel;
    assign tx_bus.wdata   = wr_word;
    assign rx_bus.wr_en   = xfer_ok && dp_write && hit_rx; // Stays 0, ro_err blocks it
    assign rx_bus.rd_en   = xfer_ok && !dp_write && hit_rx; // Data read pops
    assign rx_bus.reg_sel = rx_sel;
    assign rx_bus.wdata   = wr_word;

    // Read mux, zero when no valid read
    always_comb begin
        hrdata = '0;
        if (xfer_ok && !dp_write) begin
            if (hit_acisr) begin
                hrdata = acisr;
            end else if (hit_tx) begin
                hrdata = tx_bus.rdata;
            end else if (hit_rx) begin
                hrdata = rx_bus.rdata;
            end
        end
    end

    assign hresp  = err ? ERROR : OKAY;
    assign hready = 1'b1;

    // One channel touched per transfer
    a_one_channel: assert property (@(posedge hclk) disable iff (!hrst_b)
        !((tx_bus.wr_en || tx_bus.rd_en) && (rx_bus.wr_en || rx_bus.rd_en)));

    // No wait states once out of reset
    a_hready_high: assert property (@(posedge hclk) disable iff (!hrst_b)
        hready);

endmodule

// File: src/mbox_reg_if.sv
`timescale 1ns/1ps
//########################################
// Register access between a core port and a channel
// Single-cycle strobes, no back-pressure
// rdata is combinational from the channel
//########################################
interface mbox_reg_if
    import mbox_map_pkg::*;
();

    logic       wr_en;   // Write strobe, data phase
    logic       rd_en;   // Read strobe, data phase
    mbox_reg_e  reg_sel; // Which channel register
    mbox_word_t wdata;   // Lane-masked write data
    mbox_word_t rdata;   // Selected register contents
    logic       full;    // Channel holds an unread word

    // Core port side
    modport host (
        output wr_en,
        output rd_en,
        output reg_sel,
        output wdata,
        input  rdata,
        input  full
    );

    // Channel side
    modport regs (
        input  wr_en,
        input  rd_en,
        input  reg_sel,
        input  wdata,
        output rdata,
        output full
    );

endinterface

// File: src/mbox_ahb_pkg.sv
//########################################
// AHB-Lite field encodings
// No RETRY or SPLIT, slave answers OKAY or ERROR
//########################################
package mbox_ahb_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11  // Burst beat, not supported here
    } htrans_e;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e; // Larger sizes are errors

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_e;

endpackage

// File: src/mbox_map_pkg.sv
//########################################
// Mailbox register map, one base address
// Offsets are byte offsets in the low 8 bits
// Data registers hold one 32-bit word
//########################################
package mbox_map_pkg;

    typedef logic [31:0] mbox_word_t; // Bus and payload word

    localparam mbox_word_t MBOX_BASE_ADDR = 32'h4003_0000;

    // Register offsets from base
    localparam logic [7:0] ACISR_OFS    = 8'h04; // Interrupt status, both cores
    localparam logic [7:0] CH0_CTRL_OFS = 8'h08; // Core 0 to core 1
    localparam logic [7:0] CH0_DATA_OFS = 8'h0C;
    localparam logic [7:0] CH0_STAT_OFS = 8'h10;
    localparam logic [7:0] CH1_CTRL_OFS = 8'h14; // Core 1 to core 0
    localparam logic [7:0] CH1_DATA_OFS = 8'h18;
    localparam logic [7:0] CH1_STAT_OFS = 8'h1C;

    // Bit positions
    localparam int CTRL_INT_EN_BIT = 0; // Receiver interrupt enable
    localparam int STAT_FULL_BIT   = 0; // Word waiting
    localparam int STAT_INT_BIT    = 1; // Interrupt line state

    // Register inside a channel
    typedef enum logic [1:0] {
        CTRL = 2'd0,
        DATA = 2'd1,
        STAT = 2'd2
    } mbox_reg_e;

endpackage
